// ==== verilog/dcache_pkg.sv ====
// dcache shared widths, address layout and request payload types
`default_nettype none

package dcache_pkg;

    parameter int ADDR_W      = 64;
    parameter int DATA_W      = 64;
    parameter int MASK_W      = 8;
    parameter int OFFSET_BITS = 3;
    parameter int SET_BITS    = 6;
    // everything above index and byte offset
    parameter int TAG_W       = ADDR_W - SET_BITS - OFFSET_BITS;
    parameter int NUM_WAYS    = 2;

    typedef struct packed {
        logic [TAG_W-1:0]       tag;
        logic [SET_BITS-1:0]    index;
        logic [OFFSET_BITS-1:0] offset;
    } dcache_addr_fields_t;

    // same 64 bits, seen as a flat address or split for lookup
    typedef union packed {
        logic [ADDR_W-1:0]   raw;
        dcache_addr_fields_t fields;
    } dcache_addr_u;

    // cpu request payload, we set means store
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic [MASK_W-1:0] mask;
        logic              we;
    } cpu_req_t;

    // memory request payload, always a whole word
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
        logic              we;
    } mem_req_t;

endpackage

`default_nettype wire

// ==== verilog/dcache_tag_ram.sv ====
// dcache tag array for one way, tag plus valid bit per set with registered read
`default_nettype none

module dcache_tag_ram #(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic [IDX_W-1:0]             index_i,
    input  logic                         we_i,
    input  logic [dcache_pkg::TAG_W-1:0] tag_i,
    output logic [dcache_pkg::TAG_W-1:0] tag_o,
    output logic                         valid_o
);

    logic [dcache_pkg::TAG_W-1:0] tag_q [NUM_SETS];
    logic [NUM_SETS-1:0]          valid_q;

    // tags themselves need no clearing, valid guards them
    always_ff @(posedge clk) begin
        if (we_i) begin
            tag_q[index_i] <= tag_i;
        end
        tag_o <= tag_q[index_i];
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= '0;
            valid_o <= 1'b0;
        end else begin
            if (we_i) begin
                valid_q[index_i] <= 1'b1;
            end
            // read returns the old bit on a same-cycle write
            valid_o <= valid_q[index_i];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_data_ram.sv ====
// dcache data array for one way, byte-masked write and registered read
`default_nettype none

module dcache_data_ram #(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic                          clk,
    input  logic [IDX_W-1:0]              index_i,
    input  logic [dcache_pkg::MASK_W-1:0] mask_i,
    input  logic [dcache_pkg::DATA_W-1:0] wdata_i,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o
);

    logic [dcache_pkg::DATA_W-1:0] mem_q [NUM_SETS];

    always_ff @(posedge clk) begin
        // one write lane per mask bit, zero mask leaves the word alone
        for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
            if (mask_i[b]) begin
                mem_q[index_i][8*b +: 8] <= wdata_i[8*b +: 8];
            end
        end
        rdata_o <= mem_q[index_i];
    end

endmodule

`default_nettype wire

// ==== verilog/dcache_replace.sv ====
// dcache replacement state, per-set lru bit and per-way dirty bits, victim select
`default_nettype none

module dcache_replace #(
    parameter int  NUM_SETS = 64,
    localparam int IDX_W    = $clog2(NUM_SETS)
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [IDX_W-1:0]                index_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0] valid_i,
    input  logic                            touch_i,
    input  logic                            touch_way_i,
    input  logic                            dirty_we_i,
    input  logic                            dirty_i,
    output logic                            victim_way_o,
    output logic                            victim_dirty_o
);

    // lru bit names the way to evict next
    logic [NUM_SETS-1:0]                               lru_q;
    logic [NUM_SETS-1:0][dcache_pkg::NUM_WAYS-1:0]     dirty_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lru_q   <= '0;
            dirty_q <= '0;
        end else begin
            if (touch_i) begin
                lru_q[index_i] <= ~touch_way_i;
            end
            if (dirty_we_i) begin
                dirty_q[index_i][touch_way_i] <= dirty_i;
            end
        end
    end

    // empty way first, otherwise the older one
    always_comb begin
        if (!valid_i[0]) begin
            victim_way_o = 1'b0;
        end else if (!valid_i[1]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = lru_q[index_i];
        end
    end

    // an empty way never needs a write-back
    assign victim_dirty_o = valid_i[victim_way_o] & dirty_q[index_i][victim_way_o];

endmodule

`default_nettype wire

// ==== verilog/dcache_ctrl.sv ====
// dcache controller, lookup/write-back/refill FSM with cpu and memory req/ack handshakes
`default_nettype none

module dcache_ctrl (
    input  logic                                                  clk,
    input  logic                                                  rst,
    input  logic                                                  req_i,
    input  dcache_pkg::cpu_req_t                                  cpu_req_i,
    output logic                                                  ack_o,
    output logic [dcache_pkg::DATA_W-1:0]                         rdata_o,
    output logic                                                  mem_valid_o,
    output dcache_pkg::mem_req_t                                  mem_req_o,
    input  logic                                                  mem_ack_i,
    input  logic [dcache_pkg::DATA_W-1:0]                         mem_rdata_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_W-1:0]  tag_rd_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0]                       valid_rd_i,
    input  logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::DATA_W-1:0] data_rd_i,
    input  logic                                                  victim_way_i,
    input  logic                                                  victim_dirty_i,
    output logic [dcache_pkg::SET_BITS-1:0]                       index_o,
    output logic [dcache_pkg::NUM_WAYS-1:0]                       tag_we_o,
    output logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::MASK_W-1:0] data_mask_o,
    output logic [dcache_pkg::DATA_W-1:0]                         data_wdata_o,
    output logic                                                  touch_o,
    output logic                                                  touch_way_o,
    output logic                                                  dirty_we_o,
    output logic                                                  dirty_o
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_WB,
        S_REFILL,
        S_FILL,
        S_DONE
    } state_t;

    state_t                           state_q;
    dcache_pkg::cpu_req_t             req_q;
    dcache_pkg::mem_req_t             mem_req_q;
    logic                             mem_valid_q;
    logic                             victim_q;
    logic [dcache_pkg::DATA_W-1:0]    fill_q;
    logic [dcache_pkg::DATA_W-1:0]    rdata_q;
    logic [dcache_pkg::DATA_W-1:0]    merged;
    dcache_pkg::dcache_addr_u         cur_addr;
    dcache_pkg::dcache_addr_u         req_addr;
    dcache_pkg::dcache_addr_u         fill_addr;
    dcache_pkg::dcache_addr_u         wb_addr;
    logic [dcache_pkg::NUM_WAYS-1:0]  hit_way;
    logic                             hit;
    logic                             hit_idx;

    // rams are read on the edge that accepts the request, so index comes from
    // the live cpu payload while idle
    always_comb begin
        cur_addr.raw = (state_q == S_IDLE) ? cpu_req_i.addr : req_q.addr;
        req_addr.raw = req_q.addr;
        fill_addr.raw = req_q.addr;
        fill_addr.fields.offset = '0;
        wb_addr.fields.tag = tag_rd_i[victim_way_i];
        wb_addr.fields.index = req_addr.fields.index;
        wb_addr.fields.offset = '0;
    end

    assign index_o = cur_addr.fields.index;

    always_comb begin
        for (int w = 0; w < dcache_pkg::NUM_WAYS; w++) begin
            hit_way[w] = valid_rd_i[w] && (tag_rd_i[w] == req_addr.fields.tag);
        end
    end

    assign hit     = |hit_way;
    assign hit_idx = hit_way[1];

    // refilled word with the store bytes laid over it
    always_comb begin
        merged = fill_q;
        for (int b = 0; b < dcache_pkg::MASK_W; b++) begin
            if (req_q.we && req_q.mask[b]) begin
                merged[8*b +: 8] = req_q.wdata[8*b +: 8];
            end
        end
    end

    always_comb begin
        tag_we_o     = '0;
        data_mask_o  = '0;
        data_wdata_o = req_q.wdata;
        touch_o      = 1'b0;
        touch_way_o  = hit_idx;
        dirty_we_o   = 1'b0;
        dirty_o      = req_q.we;
        if (state_q == S_LOOKUP && hit) begin
            touch_o    = 1'b1;
            dirty_we_o = req_q.we;
            if (req_q.we) begin
                data_mask_o[hit_idx] = req_q.mask;
            end
        end else if (state_q == S_FILL) begin
            // whole line replaced, dirty follows the request kind
            touch_o               = 1'b1;
            touch_way_o           = victim_q;
            dirty_we_o            = 1'b1;
            tag_we_o[victim_q]    = 1'b1;
            data_mask_o[victim_q] = '1;
            data_wdata_o          = merged;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state_q     <= S_IDLE;
            mem_valid_q <= 1'b0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (req_i) begin
                        state_q <= S_LOOKUP;
                    end
                end
                S_LOOKUP: begin
                    if (hit) begin
                        state_q <= S_DONE;
                    end else begin
                        mem_valid_q <= 1'b1;
                        state_q     <= victim_dirty_i ? S_WB : S_REFILL;
                    end
                end
                S_WB: begin
                    if (mem_valid_q && mem_ack_i) begin
                        mem_valid_q <= 1'b0;
                    end else if (!mem_valid_q && !mem_ack_i) begin
                        // write-back closed, open the read
                        mem_valid_q <= 1'b1;
                        state_q     <= S_REFILL;
                    end
                end
                S_REFILL: begin
                    if (mem_valid_q && mem_ack_i) begin
                        mem_valid_q <= 1'b0;
                    end else if (!mem_valid_q && !mem_ack_i) begin
                        state_q <= S_FILL;
                    end
                end
                S_FILL: begin
                    state_q <= S_DONE;
                end
                S_DONE: begin
                    // hold ack until the cpu lets go
                    if (!req_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == S_IDLE && req_i) begin
            req_q <= cpu_req_i;
        end
        if (state_q == S_LOOKUP) begin
            victim_q <= victim_way_i;
            rdata_q  <= data_rd_i[hit_idx];
            if (victim_dirty_i) begin
                mem_req_q <= '{addr: wb_addr.raw, wdata: data_rd_i[victim_way_i], we: 1'b1};
            end else begin
                mem_req_q <= '{addr: fill_addr.raw, wdata: '0, we: 1'b0};
            end
        end
        if (state_q == S_WB && !mem_valid_q && !mem_ack_i) begin
            mem_req_q <= '{addr: fill_addr.raw, wdata: '0, we: 1'b0};
        end
        if (state_q == S_REFILL && mem_valid_q && mem_ack_i) begin
            fill_q <= mem_rdata_i;
        end
        if (state_q == S_FILL) begin
            rdata_q <= merged;
        end
    end

    assign ack_o       = (state_q == S_DONE);
    assign rdata_o     = rdata_q;
    assign mem_valid_o = mem_valid_q;
    assign mem_req_o   = mem_req_q;

endmodule

`default_nettype wire

// ==== verilog/dcache_top.sv ====
// dcache top, two-way write-back data cache built from tag/data rams, lru state and controller
`default_nettype none

module dcache_top #(
    parameter int NUM_SETS = 64
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          req_i,
    input  dcache_pkg::cpu_req_t          cpu_req_i,
    output logic                          ack_o,
    output logic [dcache_pkg::DATA_W-1:0] rdata_o,
    output logic                          mem_valid_o,
    output dcache_pkg::mem_req_t          mem_req_o,
    input  logic                          mem_ack_i,
    input  logic [dcache_pkg::DATA_W-1:0] mem_rdata_i
);

    localparam int IDX_W = $clog2(NUM_SETS);

    logic [dcache_pkg::SET_BITS-1:0]                             index;
    dcache_pkg::dcache_addr_u                                    cpu_addr;
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::TAG_W-1:0]      tag_rd;
    logic [dcache_pkg::NUM_WAYS-1:0]                             valid_rd;
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::DATA_W-1:0]     data_rd;
    logic [dcache_pkg::NUM_WAYS-1:0]                             tag_we;
    logic [dcache_pkg::NUM_WAYS-1:0][dcache_pkg::MASK_W-1:0]     data_mask;
    logic [dcache_pkg::DATA_W-1:0]                               data_wdata;
    logic                                                        victim_way;
    logic                                                        victim_dirty;
    logic                                                        touch;
    logic                                                        touch_way;
    logic                                                        dirty_we;
    logic                                                        dirty;

    // cpu payload is held until ack, so its tag is still valid at fill time
    assign cpu_addr.raw = cpu_req_i.addr;

    for (genvar w = 0; w < dcache_pkg::NUM_WAYS; w++) begin : g_way
        dcache_tag_ram #(
            .NUM_SETS (NUM_SETS)
        ) i_tag_ram (
            .clk     (clk),
            .rst     (rst),
            .index_i (index[IDX_W-1:0]),
            .we_i    (tag_we[w]),
            .tag_i   (cpu_addr.fields.tag),
            .tag_o   (tag_rd[w]),
            .valid_o (valid_rd[w])
        );

        dcache_data_ram #(
            .NUM_SETS (NUM_SETS)
        ) i_data_ram (
            .clk     (clk),
            .index_i (index[IDX_W-1:0]),
            .mask_i  (data_mask[w]),
            .wdata_i (data_wdata),
            .rdata_o (data_rd[w])
        );
    end

    dcache_replace #(
        .NUM_SETS (NUM_SETS)
    ) i_replace (
        .clk            (clk),
        .rst            (rst),
        .index_i        (index[IDX_W-1:0]),
        .valid_i        (valid_rd),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .dirty_we_i     (dirty_we),
        .dirty_i        (dirty),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty)
    );

    dcache_ctrl i_ctrl (
        .clk            (clk),
        .rst            (rst),
        .req_i          (req_i),
        .cpu_req_i      (cpu_req_i),
        .ack_o          (ack_o),
        .rdata_o        (rdata_o),
        .mem_valid_o    (mem_valid_o),
        .mem_req_o      (mem_req_o),
        .mem_ack_i      (mem_ack_i),
        .mem_rdata_i    (mem_rdata_i),
        .tag_rd_i       (tag_rd),
        .valid_rd_i     (valid_rd),
        .data_rd_i      (data_rd),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .index_o        (index),
        .tag_we_o       (tag_we),
        .data_mask_o    (data_mask),
        .data_wdata_o   (data_wdata),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .dirty_we_o     (dirty_we),
        .dirty_o        (dirty)
    );

endmodule

`default_nettype wire

// ==== tests/dcache_sva.sv ====
// dcache handshake assertions, bound into the cache top level
`default_nettype none

module dcache_sva (
    input logic                 clk,
    input logic                 rst,
    input logic                 req_i,
    input logic                 ack_o,
    input logic                 mem_valid_o,
    input dcache_pkg::mem_req_t mem_req_o,
    input logic                 mem_ack_i
);

    // cpu may drop req_i in the same cycle ack_o first shows
    property ack_follows_req;
        @(posedge clk) disable iff (!rst)
            $rose(ack_o) |-> $past(req_i);
    endproperty

    property mem_req_held;
        @(posedge clk) disable iff (!rst)
            mem_valid_o && !mem_ack_i |=> mem_valid_o && $stable(mem_req_o);
    endproperty

    property quiet_after_reset;
        @(posedge clk) $rose(rst) |-> !ack_o && !mem_valid_o;
    endproperty

    a_ack_follows_req: assert property (ack_follows_req)
        else $error("ack_o rose without a request");
    a_mem_req_held: assert property (mem_req_held)
        else $error("memory request changed before mem_ack_i");
    a_quiet_after_reset: assert property (quiet_after_reset)
        else $error("handshake outputs active right after reset");

endmodule

bind dcache_top dcache_sva i_dcache_sva (
    .clk         (clk),
    .rst         (rst),
    .req_i       (req_i),
    .ack_o       (ack_o),
    .mem_valid_o (mem_valid_o),
    .mem_req_o   (mem_req_o),
    .mem_ack_i   (mem_ack_i)
);

`default_nettype wire

// ==== tests/dcache_tb.sv ====
// dcache testbench, cpu driver, memory model and load checker against a shadow memory
`default_nettype none

module dcache_tb;

    localparam int TIMEOUT = 200;

    logic                          clk;
    logic                          rst;
    logic                          req_i;
    dcache_pkg::cpu_req_t          cpu_req_i;
    logic                          ack_o;
    logic [dcache_pkg::DATA_W-1:0] rdata_o;
    logic                          mem_valid_o;
    dcache_pkg::mem_req_t          mem_req_o;
    logic                          mem_ack_i;
    logic [dcache_pkg::DATA_W-1:0] mem_rdata_i;

    integer      seed = 32'h3df1b148;
    int          load_checks = 0;
    int          last_latency;
    logic [63:0] last_rdata;
    // memory behind the cache, and what the cpu should see
    logic [63:0] mem_words [logic [63:0]];
    logic [63:0] shadow [logic [63:0]];
    // write-backs as memory saw them
    logic [63:0] wb_addr_q [$];
    logic [63:0] wb_data_q [$];

    dcache_top #(
        .NUM_SETS (64)
    ) i_dcache_top (
        .clk         (clk),
        .rst         (rst),
        .req_i       (req_i),
        .cpu_req_i   (cpu_req_i),
        .ack_o       (ack_o),
        .rdata_o     (rdata_o),
        .mem_valid_o (mem_valid_o),
        .mem_req_o   (mem_req_o),
        .mem_ack_i   (mem_ack_i),
        .mem_rdata_i (mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    function automatic logic [63:0] init_pattern(input logic [63:0] addr);
        return {addr[31:0], addr[31:0]};
    endfunction

    // applies one request to the shadow memory, returns the word a load sees
    function automatic logic [63:0] ref_access(input dcache_pkg::cpu_req_t req);
        logic [63:0] word_addr;
        logic [63:0] word;
        word_addr = {req.addr[63:3], 3'b000};
        word = shadow.exists(word_addr) ? shadow[word_addr] : init_pattern(word_addr);
        for (int b = 0; b < 8; b++) begin
            if (req.we && req.mask[b]) begin
                word[8*b +: 8] = req.wdata[8*b +: 8];
            end
        end
        shadow[word_addr] = word;
        return word;
    endfunction

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        abort_run($sformatf("[ERROR] %s: got 0x%h, expected 0x%h", name, got, exp));
    endtask

    // one cpu request, req_i held for hold extra cycles once ack_o is up
    task automatic cpu_access(input logic [63:0] addr, input logic [63:0] wdata,
                              input logic [7:0] mask, input logic we, input int hold);
        int waited;
        cpu_req_i = '{addr: addr, wdata: wdata, mask: mask, we: we};
        req_i = 1'b1;
        waited = 0;
        while (!ack_o) begin
            @(posedge clk);
            #1;
            waited++;
            assert (waited <= TIMEOUT) else abort_run("timeout waiting for ack_o to rise");
        end
        last_latency = waited;
        last_rdata = rdata_o;
        repeat (hold) begin
            @(posedge clk);
            #1;
            assert (ack_o) else abort_run("ack_o fell while req_i was still high");
        end
        req_i = 1'b0;
        waited = 0;
        while (ack_o) begin
            @(posedge clk);
            #1;
            waited++;
            assert (waited <= TIMEOUT) else abort_run("timeout waiting for ack_o to fall");
        end
    endtask

    // memory model, acks after 0 to 3 cycles
    initial begin
        logic [1:0]           delay;
        integer               r;
        int                   waited;
        dcache_pkg::mem_req_t req;
        mem_ack_i = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(posedge clk);
            #1;
            if (mem_valid_o) begin
                req = mem_req_o;
                r = $random(seed);
                delay = r[1:0];
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                if (req.we) begin
                    mem_words[req.addr] = req.wdata;
                    wb_addr_q.push_back(req.addr);
                    wb_data_q.push_back(req.wdata);
                end else if (mem_words.exists(req.addr)) begin
                    mem_rdata_i = mem_words[req.addr];
                end else begin
                    mem_rdata_i = init_pattern(req.addr);
                end
                mem_ack_i = 1'b1;
                waited = 0;
                while (mem_valid_o) begin
                    @(posedge clk);
                    #1;
                    waited++;
                    assert (waited <= TIMEOUT) else
                        abort_run("timeout waiting for mem_valid_o to fall");
                end
                mem_ack_i = 1'b0;
            end
        end
    end

    // compares each load as ack_o rises, and rdata_o while ack_o stays up
    initial begin
        logic        ack_seen;
        logic [63:0] expected;
        logic [63:0] held;
        ack_seen = 1'b0;
        forever begin
            @(negedge clk);
            if (ack_o && !ack_seen) begin
                expected = ref_access(cpu_req_i);
                if (!cpu_req_i.we) begin
                    assert (rdata_o == expected) else
                        report_mismatch("rdata_o", rdata_o, expected);
                    load_checks++;
                end
                held = rdata_o;
            end else if (ack_o) begin
                assert (rdata_o == held) else report_mismatch("rdata_o", rdata_o, held);
            end
            ack_seen = ack_o;
        end
    end

    initial begin
        logic [63:0] pool [12];
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] c;
        logic [3:0]  slot;
        integer      r;
        integer      d_hi;
        integer      d_lo;
        rst = 1'b0;
        req_i = 1'b0;
        cpu_req_i = '0;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b1;
        @(posedge clk);
        #1;

        a = 64'h0000_00ab_cde0_1100;
        cpu_access(a, '0, '0, 1'b0, 0);
        assert (last_rdata == init_pattern(a)) else
            report_mismatch("rdata_o", last_rdata, init_pattern(a));

        // partial store on a miss, then on a hit
        a = 64'h0000_0042_0000_0088;
        cpu_access(a, 64'h1122_3344_5566_7788, 8'b0010_0110, 1'b1, 0);
        cpu_access(a, '0, '0, 1'b0, 0);
        assert (last_rdata == 64'h0000_3388_0066_7788) else
            report_mismatch("rdata_o", last_rdata, 64'h0000_3388_0066_7788);
        cpu_access(a, 64'hcafe_f00d_dead_beef, 8'b1000_0001, 1'b1, 0);
        assert (last_latency == 2) else
            abort_run("store to a cached word did not hit in 2 cycles");
        cpu_access(a, '0, '0, 1'b0, 0);
        assert (last_latency == 2) else
            abort_run("load of a cached word did not hit in 2 cycles");
        assert (last_rdata == 64'hca00_3388_0066_77ef) else
            report_mismatch("rdata_o", last_rdata, 64'hca00_3388_0066_77ef);

        // set 5, third store evicts the first
        a = 64'h1028;
        b = 64'h2028;
        c = 64'h3028;
        cpu_access(a, 64'h0123_4567_89ab_cdef, 8'hff, 1'b1, 0);
        cpu_access(b, 64'hfedc_ba98_7654_3210, 8'h0f, 1'b1, 0);
        wb_addr_q.delete();
        wb_data_q.delete();
        cpu_access(c, 64'h5555_aaaa_5555_aaaa, 8'hf0, 1'b1, 0);
        assert (wb_addr_q.size() == 1) else
            abort_run("eviction did not write back exactly one word");
        assert (wb_addr_q[0] == a) else report_mismatch("mem_req_o.addr", wb_addr_q[0], a);
        assert (wb_data_q[0] == shadow[a]) else
            report_mismatch("mem_req_o.wdata", wb_data_q[0], shadow[a]);

        // set 9, reloading a leaves b as the older way
        a = 64'h5048;
        b = 64'h6048;
        c = 64'h7048;
        cpu_access(a, 64'h1111_2222_3333_4444, 8'hff, 1'b1, 0);
        cpu_access(b, 64'h9999_8888_7777_6666, 8'h3c, 1'b1, 0);
        cpu_access(a, '0, '0, 1'b0, 0);
        wb_addr_q.delete();
        wb_data_q.delete();
        cpu_access(c, 64'h0f0f_0f0f_0f0f_0f0f, 8'hff, 1'b1, 0);
        assert (wb_addr_q.size() == 1) else
            abort_run("LRU eviction did not write back exactly one word");
        assert (wb_addr_q[0] == b) else report_mismatch("mem_req_o.addr", wb_addr_q[0], b);
        assert (wb_data_q[0] == shadow[b]) else
            report_mismatch("mem_req_o.wdata", wb_data_q[0], shadow[b]);

        // four tags in each of sets 40 to 42
        for (int k = 0; k < 12; k++) begin
            pool[k] = (64'(k / 3 + 1) << 9) | (64'(40 + k % 3) << 3);
        end
        for (int i = 0; i < 300; i++) begin
            r = $random(seed);
            d_hi = $random(seed);
            d_lo = $random(seed);
            slot = 4'((r & 32'hff) % 12);
            cpu_access(pool[slot], {d_hi, d_lo}, r[31:24], r[16], 0);
        end

        // back-pressure on a miss and on a hit
        a = 64'h0000_0077_0000_0190;
        cpu_access(a, '0, '0, 1'b0, 6);
        cpu_access(a, '0, '0, 1'b0, 3);

        if (load_checks > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            abort_run("the checker compared no loads");
        end
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
verilog/dcache_pkg.sv
verilog/dcache_tag_ram.sv
verilog/dcache_data_ram.sv
verilog/dcache_replace.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
tests/dcache_sva.sv
tests/dcache_tb.sv

// ==== Makefile ====
# Verilator build and run of the dcache testbench
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, and look for the pass line in $(LOG)"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -j 0 --top-module dcache_tb -f verilog.f -Mdir obj_dir
	./obj_dir/Vdcache_tb | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
